//--- design/rob_defs.svh
// reorder buffer macros: buffer depth and field widths

`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// --------------------
// buffer geometry
// --------------------
`define ROB_DEPTH   32   // entries in the circular buffer
`define ROB_IDX_W   5    // entry index, head and tail add a wrap bit on top

// --------------------
// field widths
// --------------------
`define PRF_TAG_W   6    // physical register tag
`define LREG_W      5    // architectural register number
`define BR_MASK_W   4    // one bit per in-flight branch
`define PC_W        64
`define FL_HEAD_W   5    // free-list head pointer

`endif

//--- design/rob_pkg.sv
// reorder buffer package: vector typedefs and packed payload structs

`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

	// --------------------
	// plain vectors
	// --------------------
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [`ROB_IDX_W:0]   rob_ptr_t;  // msb is the wrap bit
	typedef logic [`PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [`LREG_W-1:0]    lreg_t;
	typedef logic [`BR_MASK_W-1:0] br_mask_t;
	typedef logic [`PC_W-1:0]      pc_t;
	typedef logic [`FL_HEAD_W-1:0] fl_head_t;

	// --------------------
	// payloads
	// --------------------

	// everything captured when an instruction enters the buffer
	typedef struct packed {
		prf_tag_t old_tag;      // previous mapping, freed at retire
		prf_tag_t new_tag;      // mapping handed to the arch map
		lreg_t    ldest;
		pc_t      pc;
		logic     br_flag;
		logic     pred_taken;
		pc_t      pred_target;
		br_mask_t br_mask;
		fl_head_t fl_head;      // free-list head snapshot for recovery
	} rob_dispatch_t;

	typedef struct packed {
		rob_ptr_t ptr;
		logic     taken;        // actual branch outcome
	} rob_complete_t;

	typedef struct packed {
		rob_ptr_t ptr;
		logic     taken;
		pc_t      target;
	} rob_resolve_t;

	typedef struct packed {
		prf_tag_t old_tag;
		prf_tag_t new_tag;
		lreg_t    ldest;
	} rob_retire_t;

	// stored prediction of the entry being resolved
	typedef struct packed {
		logic     br_flag;
		logic     pred_taken;
		pc_t      pred_target;
		br_mask_t br_mask;
		fl_head_t fl_head;
	} rob_branch_info_t;

	typedef struct packed {
		br_mask_t br_mask;
		fl_head_t fl_head;
	} rob_recover_t;

endpackage

`default_nettype wire

//--- design/rob_ptr_ctrl.sv
// head and tail pointer control with full detection, dispatch gating and rollback

`default_nettype none

`include "rob_defs.svh"

module rob_ptr_ctrl
	import rob_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,

	input  wire logic     dispatch_valid_i,
	input  wire logic     retire_valid_i,
	input  wire logic     recover_i,
	input  wire rob_ptr_t recover_ptr_i,      // branch that mispredicted

	output rob_ptr_t      head_ptr_o,
	output rob_ptr_t      tail_ptr_o,
	output logic          dispatch_accept_o,
	output logic          stall_o
);

	// --------------------
	// pointer state
	// --------------------
	rob_ptr_t head_q;
	rob_ptr_t tail_q;
	rob_ptr_t head_d;
	rob_ptr_t tail_d;
	logic     full;

	// same index, opposite wrap bit
	assign full = (head_q ^ tail_q) == {1'b1, {`ROB_IDX_W{1'b0}}};

	// a retiring head frees a slot in the same cycle
	assign stall_o = full & ~retire_valid_i;

	assign dispatch_accept_o = dispatch_valid_i & ~stall_o & ~recover_i;

	// --------------------
	// next pointers
	// --------------------
	always_comb begin
		head_d = head_q;
		if (retire_valid_i) begin
			head_d = head_q + rob_ptr_t'(1);
		end
	end

	always_comb begin
		tail_d = tail_q;
		if (recover_i) begin
			// squash everything younger than the branch
			tail_d = recover_ptr_i + rob_ptr_t'(1);
		end else if (dispatch_accept_o) begin
			tail_d = tail_q + rob_ptr_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			head_q <= head_d;
			tail_q <= tail_d;
		end
	end

	assign head_ptr_o = head_q;
	assign tail_ptr_o = tail_q;

	// --------------------
	// checks
	// --------------------

	// neither dispatch past a full buffer nor a rollback may overfill it
	no_overfill: assert property (
		@(posedge clk) disable iff (rst)
		rob_ptr_t'(tail_q - head_q) <= rob_ptr_t'(`ROB_DEPTH)
	) else $error("rob_ptr_ctrl: buffer holds more entries than it has slots");

endmodule

`default_nettype wire

//--- design/rob_entry_store.sv
// reorder buffer entry array with dispatch, completion and retire writes and read ports

`default_nettype none

`include "rob_defs.svh"

module rob_entry_store
	import rob_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,

	// dispatch at tail
	input  wire logic          dispatch_accept_i,
	input  wire rob_dispatch_t dispatch_i,
	input  wire rob_ptr_t      head_ptr_i,
	input  wire rob_ptr_t      tail_ptr_i,

	// completion from the functional units
	input  wire logic          complete_valid_i,
	input  wire rob_complete_t complete_i,

	// read ports
	input  wire rob_ptr_t      resolve_ptr_i,
	input  wire rob_ptr_t      npc_rd_ptr_i,

	output logic               retire_valid_o,
	output rob_retire_t        retire_o,
	output rob_branch_info_t   branch_info_o,
	output pc_t                npc_o
);

	// --------------------
	// storage
	// --------------------
	rob_dispatch_t          entry_q [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0]  done_q;
	logic [`ROB_DEPTH-1:0]  taken_q;     // actual outcome as reported by the unit

	rob_idx_t head_idx;
	rob_idx_t tail_idx;
	rob_idx_t cmp_idx;
	rob_idx_t res_idx;
	rob_idx_t npc_idx;
	logic     not_empty;

	assign head_idx = head_ptr_i[`ROB_IDX_W-1:0];
	assign tail_idx = tail_ptr_i[`ROB_IDX_W-1:0];
	assign cmp_idx  = complete_i.ptr[`ROB_IDX_W-1:0];
	assign res_idx  = resolve_ptr_i[`ROB_IDX_W-1:0];
	assign npc_idx  = npc_rd_ptr_i[`ROB_IDX_W-1:0];

	// squashed slots past a rolled back tail may still carry a done bit
	assign not_empty = head_ptr_i != tail_ptr_i;

	// --------------------
	// status bits
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q  <= '0;
			taken_q <= '0;
		end else begin
			if (retire_valid_o) begin
				done_q[head_idx]  <= 1'b0;  // slot goes back to the pool
				taken_q[head_idx] <= 1'b0;
			end
			if (complete_valid_i) begin
				done_q[cmp_idx]  <= 1'b1;
				taken_q[cmp_idx] <= complete_i.taken;
			end
			// last, so a full buffer retiring and refilling ends up fresh
			if (dispatch_accept_i) begin
				done_q[tail_idx]  <= 1'b0;
				taken_q[tail_idx] <= 1'b0;
			end
		end
	end

	// payload fields only change on dispatch
	always_ff @(posedge clk) begin
		if (dispatch_accept_i) begin
			entry_q[tail_idx] <= dispatch_i;
		end
	end

	// --------------------
	// head port
	// --------------------
	assign retire_valid_o = done_q[head_idx] & not_empty;

	always_comb begin
		retire_o.old_tag = entry_q[head_idx].old_tag;   // to free list
		retire_o.new_tag = entry_q[head_idx].new_tag;   // to arch map
		retire_o.ldest   = entry_q[head_idx].ldest;
	end

	// --------------------
	// branch and npc ports
	// --------------------
	always_comb begin
		branch_info_o.br_flag     = entry_q[res_idx].br_flag;
		branch_info_o.pred_taken  = entry_q[res_idx].pred_taken;
		branch_info_o.pred_target = entry_q[res_idx].pred_target;
		branch_info_o.br_mask     = entry_q[res_idx].br_mask;
		branch_info_o.fl_head     = entry_q[res_idx].fl_head;
	end

	assign npc_o = entry_q[npc_idx].pc + pc_t'(4);  // fall-through for the branch unit

	// --------------------
	// checks
	// --------------------

	// with head on tail nothing is in flight, so no unit may report that slot
	no_complete_when_empty: assert property (
		@(posedge clk) disable iff (rst)
		complete_valid_i && (head_ptr_i == tail_ptr_i) |-> complete_i.ptr != tail_ptr_i
	) else $error("rob_entry_store: completion of an empty slot");

endmodule

`default_nettype wire

//--- design/rob_branch_check.sv
// branch resolution: misprediction detection and recovery payload

`default_nettype none

`include "rob_defs.svh"

module rob_branch_check
	import rob_pkg::*;
(
	input  wire logic             resolve_valid_i,
	input  wire rob_resolve_t     resolve_i,
	input  wire rob_branch_info_t branch_info_i,     // stored prediction at resolve_i.ptr

	output logic                  recover_o,
	output logic                  branch_correct_o,
	output rob_recover_t          recover_info_o
);

	// --------------------
	// compare
	// --------------------
	logic is_branch;
	logic dir_wrong;
	logic tgt_wrong;
	logic mispredict;

	// non-branch entries never trigger either outcome
	assign is_branch = resolve_valid_i & branch_info_i.br_flag;

	assign dir_wrong = resolve_i.taken != branch_info_i.pred_taken;

	// target only matters when both sides went taken
	assign tgt_wrong = resolve_i.taken & branch_info_i.pred_taken &
		(resolve_i.target != branch_info_i.pred_target);

	assign mispredict = dir_wrong | tgt_wrong;

	// --------------------
	// outcome
	// --------------------
	always_comb begin
		recover_o        = 1'b0;
		branch_correct_o = 1'b0;
		recover_info_o   = '0;
		if (is_branch) begin
			if (mispredict) begin
				recover_o              = 1'b1;
				recover_info_o.br_mask = branch_info_i.br_mask;  // squash younger tags
				recover_info_o.fl_head = branch_info_i.fl_head;  // free list rewinds here
			end else begin
				branch_correct_o = 1'b1;   // clear the mask bit downstream
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rob_top.sv
// reorder buffer top: pointer control, entry store and branch check

`default_nettype none

`include "rob_defs.svh"

module rob_top
	import rob_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,

	// --------------------
	// dispatch
	// --------------------
	input  wire logic          dispatch_valid_i,
	input  wire rob_dispatch_t dispatch_i,
	output rob_ptr_t           tail_o,           // slot the next dispatch receives
	output logic               stall_o,

	// --------------------
	// completion and resolution
	// --------------------
	input  wire logic          complete_valid_i,
	input  wire rob_complete_t complete_i,
	input  wire logic          resolve_valid_i,
	input  wire rob_resolve_t  resolve_i,

	// --------------------
	// retire and recovery
	// --------------------
	output logic               retire_valid_o,
	output rob_retire_t        retire_o,
	output logic               recover_o,
	output logic               branch_correct_o,
	output rob_recover_t       recover_info_o,

	// npc read for the branch unit
	input  wire rob_ptr_t      npc_rd_ptr_i,
	output pc_t                npc_o
);

	rob_ptr_t         head_ptr;
	rob_ptr_t         tail_ptr;
	logic             dispatch_accept;
	rob_branch_info_t branch_info;

	rob_ptr_ctrl u_ptr_ctrl (
		.clk               (clk),
		.rst               (rst),
		.dispatch_valid_i  (dispatch_valid_i),
		.retire_valid_i    (retire_valid_o),
		.recover_i         (recover_o),
		.recover_ptr_i     (resolve_i.ptr),
		.head_ptr_o        (head_ptr),
		.tail_ptr_o        (tail_ptr),
		.dispatch_accept_o (dispatch_accept),
		.stall_o           (stall_o)
	);

	rob_entry_store u_entry_store (
		.clk               (clk),
		.rst               (rst),
		.dispatch_accept_i (dispatch_accept),
		.dispatch_i        (dispatch_i),
		.head_ptr_i        (head_ptr),
		.tail_ptr_i        (tail_ptr),
		.complete_valid_i  (complete_valid_i),
		.complete_i        (complete_i),
		.resolve_ptr_i     (resolve_i.ptr),      // branch info read for the checker
		.npc_rd_ptr_i      (npc_rd_ptr_i),
		.retire_valid_o    (retire_valid_o),
		.retire_o          (retire_o),
		.branch_info_o     (branch_info),
		.npc_o             (npc_o)
	);

	rob_branch_check u_branch_check (
		.resolve_valid_i   (resolve_valid_i),
		.resolve_i         (resolve_i),
		.branch_info_i     (branch_info),
		.recover_o         (recover_o),
		.branch_correct_o  (branch_correct_o),
		.recover_info_o    (recover_info_o)
	);

	assign tail_o = tail_ptr;

endmodule

`default_nettype wire

//--- bench/rob_tb.sv
// reorder buffer testbench: clock, reset, seeded random stimulus, queue model and checks

`default_nettype none

`include "rob_defs.svh"

module rob_tb
	import rob_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int T2_LEN = 400;
	localparam int T3_LEN = 6 * `ROB_DEPTH;
	localparam int T4_LEN = 64;
	localparam int T5_LEN = 400;
	localparam int CYCLE_LIMIT = RESET_CYCLES + T2_LEN + T3_LEN + T4_LEN + T5_LEN + 200;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		rob_ptr_t      ptr;
		logic          done;
		rob_dispatch_t d;
	} model_entry_t;

	logic clk;
	logic rst;
	logic dispatch_valid_i;
	rob_dispatch_t dispatch_i;
	logic complete_valid_i;
	rob_complete_t complete_i;
	logic resolve_valid_i;
	rob_resolve_t resolve_i;
	rob_ptr_t npc_rd_ptr_i;
	rob_ptr_t tail_o;
	logic stall_o;
	logic retire_valid_o;
	rob_retire_t retire_o;
	logic recover_o;
	logic branch_correct_o;
	rob_recover_t recover_info_o;
	pc_t npc_o;

	model_entry_t m_q[$];
	rob_ptr_t m_tail;
	logic disp_taken;   // last driven dispatch went in
	logic res_mis;      // outcome chosen for the pending resolve
	logic npc_chk;
	int npc_sel;
	int br_pct;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int cycle_cnt = 0;
	int n_rec = 0;
	int n_ok = 0;
	int n_nb = 0;
	int n_npc = 0;

	rob_top UUT (
		.clk(clk), .rst(rst),
		.dispatch_valid_i(dispatch_valid_i), .dispatch_i(dispatch_i),
		.tail_o(tail_o), .stall_o(stall_o),
		.complete_valid_i(complete_valid_i), .complete_i(complete_i),
		.resolve_valid_i(resolve_valid_i), .resolve_i(resolve_i),
		.retire_valid_o(retire_valid_o), .retire_o(retire_o),
		.recover_o(recover_o), .branch_correct_o(branch_correct_o),
		.recover_info_o(recover_info_o),
		.npc_rd_ptr_i(npc_rd_ptr_i), .npc_o(npc_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("run stopped by timeout after %0d cycles", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_bit(string name, logic got, logic exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %b exp %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_retire(string name, rob_retire_t got, rob_retire_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_recover(string name, rob_recover_t got, rob_recover_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_npc(string name, pc_t got, pc_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_ptr(string name, rob_ptr_t got, rob_ptr_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_failure(string what);
		$display("%0t %s", $time, what);
		err_cnt++;
	endtask

	task automatic report_test(string name, int errs_before);
		test_cnt++;
		$display("test %0d %-26s %s (%0d errors)", test_cnt, name,
			(err_cnt == errs_before) ? "ok" : "FAILED", err_cnt - errs_before);
	endtask

	// --------------------
	// stimulus helpers
	// --------------------
	function automatic logic rand_pct(int pct);
		return $urandom_range(99, 0) < pct;
	endfunction

	function automatic rob_dispatch_t make_dispatch();
		rob_dispatch_t d;
		d.old_tag     = prf_tag_t'($urandom);
		d.new_tag     = prf_tag_t'($urandom);
		d.ldest       = lreg_t'($urandom);
		d.pc          = pc_t'({$urandom, $urandom & 32'hffff_fffc});
		d.br_flag     = rand_pct(br_pct);
		d.pred_taken  = $urandom_range(1, 0);
		d.pred_target = pc_t'({$urandom, $urandom});
		d.br_mask     = br_mask_t'($urandom);
		d.fl_head     = fl_head_t'($urandom);
		return d;
	endfunction

	function automatic int find_idx(rob_ptr_t p);
		for (int j = 0; j < m_q.size(); j++) begin
			if (m_q[j].ptr == p) begin
				return j;
			end
		end
		return -1;
	endfunction

	// new inputs for one cycle, a held dispatch stays on the bus
	task automatic drive(int p_disp, int p_cmp, int p_res);
		int start;
		int i;
		int mode;
		logic found;
		model_entry_t e;
		complete_valid_i = 1'b0;
		resolve_valid_i  = 1'b0;
		found = 1'b0;
		if (!(dispatch_valid_i && !disp_taken)) begin
			dispatch_valid_i = rand_pct(p_disp);
			dispatch_i = make_dispatch();
		end
		if (m_q.size() > 0 && rand_pct(p_cmp)) begin
			start = $urandom_range(m_q.size() - 1, 0);
			for (int j = 0; j < m_q.size(); j++) begin
				i = (start + j) % m_q.size();
				if (!m_q[i].done && !found) begin
					found = 1'b1;
					complete_valid_i = 1'b1;
					complete_i.ptr   = m_q[i].ptr;
					complete_i.taken = $urandom_range(1, 0);
				end
			end
		end
		if (!complete_valid_i && m_q.size() > 0 && rand_pct(p_res)) begin
			e = m_q[$urandom_range(m_q.size() - 1, 0)];
			mode = $urandom_range(2, 0);   // 0 match, 1 direction miss, 2 target miss
			resolve_valid_i  = 1'b1;
			resolve_i.ptr    = e.ptr;
			resolve_i.target = pc_t'({$urandom, $urandom});
			if (mode == 0) begin
				resolve_i.taken = e.d.pred_taken;
				if (e.d.pred_taken) begin
					resolve_i.target = e.d.pred_target;
				end
			end else if (mode == 2 && e.d.pred_taken) begin
				resolve_i.taken  = 1'b1;
				resolve_i.target = e.d.pred_target ^ pc_t'(64'h40);
			end else begin
				resolve_i.taken = !e.d.pred_taken;
			end
			res_mis = (mode != 0);
		end
		npc_chk = m_q.size() > 0;
		if (npc_chk) begin
			npc_sel = $urandom_range(m_q.size() - 1, 0);
			npc_rd_ptr_i = m_q[npc_sel].ptr;
		end
	endtask

	// --------------------
	// check one cycle, then advance the model across the edge
	// --------------------
	task automatic step();
		int k;
		logic exp_ret;
		logic exp_stall;
		logic exp_rec;
		logic exp_ok;
		logic exp_acc;
		rob_retire_t r;
		rob_recover_t rc;
		model_entry_t e;
		#5;
		exp_ret   = (m_q.size() > 0) && m_q[0].done;
		exp_stall = (m_q.size() == `ROB_DEPTH) && !exp_ret;
		exp_rec   = 1'b0;
		exp_ok    = 1'b0;
		rc        = '0;
		k         = -1;
		if (resolve_valid_i) begin
			k = find_idx(resolve_i.ptr);
			if (k >= 0 && m_q[k].d.br_flag) begin
				exp_rec = res_mis;
				exp_ok  = !res_mis;
				if (res_mis) begin
					rc.br_mask = m_q[k].d.br_mask;
					rc.fl_head = m_q[k].d.fl_head;
				end
			end
			if (exp_rec) n_rec++;
			else if (exp_ok) n_ok++;
			else n_nb++;
		end
		check_ptr("tail_o", tail_o, m_tail);
		check_bit("stall_o", stall_o, exp_stall);
		check_bit("retire_valid_o", retire_valid_o, exp_ret);
		if (exp_ret) begin
			r.old_tag = m_q[0].d.old_tag;
			r.new_tag = m_q[0].d.new_tag;
			r.ldest   = m_q[0].d.ldest;
			check_retire("retire_o", retire_o, r);
		end
		check_bit("recover_o", recover_o, exp_rec);
		check_bit("branch_correct_o", branch_correct_o, exp_ok);
		check_recover("recover_info_o", recover_info_o, rc);
		if (npc_chk) begin
			check_npc("npc_o", npc_o, m_q[npc_sel].d.pc + pc_t'(4));
			n_npc++;
		end
		exp_acc = dispatch_valid_i && !exp_stall && !exp_rec;
		if (exp_rec) begin
			while (m_q.size() > k + 1) void'(m_q.pop_back());   // drop younger entries
			m_tail = resolve_i.ptr + rob_ptr_t'(1);
		end
		if (exp_ret) void'(m_q.pop_front());
		if (complete_valid_i) begin
			k = find_idx(complete_i.ptr);
			if (k >= 0) begin
				e = m_q[k];
				e.done = 1'b1;
				m_q[k] = e;
			end
		end
		if (exp_acc) begin
			e.ptr  = m_tail;
			e.done = 1'b0;
			e.d    = dispatch_i;
			m_q.push_back(e);
			m_tail = m_tail + rob_ptr_t'(1);
		end
		disp_taken = exp_acc;
		@(posedge clk);
		#2;
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		int errs;
		int n;
		int unsigned seed_ret;
		rob_ptr_t t0;
		seed_ret = $urandom(32'h09cb_9e22);
		rst = 1'b1;
		dispatch_valid_i = 1'b0;
		dispatch_i = '0;
		complete_valid_i = 1'b0;
		complete_i = '0;
		resolve_valid_i = 1'b0;
		resolve_i = '0;
		npc_rd_ptr_i = '0;
		m_tail = '0;
		disp_taken = 1'b0;
		res_mis = 1'b0;
		npc_chk = 1'b0;
		npc_sel = 0;
		br_pct = 30;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		errs = err_cnt;
		#5;
		check_bit("stall_o", stall_o, 1'b0);
		check_bit("retire_valid_o", retire_valid_o, 1'b0);
		check_bit("recover_o", recover_o, 1'b0);
		check_bit("branch_correct_o", branch_correct_o, 1'b0);
		check_ptr("tail_o", tail_o, '0);
		@(posedge clk);
		#2;
		report_test("reset state", errs);

		errs = err_cnt;
		repeat (T2_LEN) begin
			drive(60, 50, 0);
			step();
		end
		report_test("random dispatch/complete", errs);

		// drain, fill without completing, then free the head
		errs = err_cnt;
		n = 0;
		while ((m_q.size() > 0 || dispatch_valid_i) && n < 4 * `ROB_DEPTH) begin
			drive(0, 100, 0);
			step();
			n++;
		end
		if (m_q.size() != 0) report_failure("buffer did not drain before the fill");
		repeat (`ROB_DEPTH) begin
			drive(100, 0, 0);
			step();
		end
		t0 = tail_o;
		repeat (3) begin
			drive(100, 0, 0);
			step();
		end
		check_bit("stall_o while full", stall_o, 1'b1);
		check_ptr("tail_o while full", tail_o, t0);
		drive(100, 0, 0);
		complete_valid_i = 1'b1;
		complete_i.ptr   = m_q[0].ptr;
		complete_i.taken = 1'b0;
		step();
		drive(100, 0, 0);
		step();   // retire cycle takes the held dispatch
		check_ptr("tail_o after retire", tail_o, t0 + rob_ptr_t'(1));
		report_test("full stall", errs);

		errs = err_cnt;
		n_npc = 0;
		repeat (T4_LEN) begin
			drive(50, 30, 0);
			step();
		end
		if (n_npc == 0) report_failure("no npc read was checked");
		report_test("npc read", errs);

		errs = err_cnt;
		br_pct = 60;
		repeat (T5_LEN) begin
			drive(50, 30, 25);
			step();
		end
		if (n_rec == 0) report_failure("no mispredicted branch was resolved");
		if (n_ok == 0) report_failure("no correctly predicted branch was resolved");
		if (n_nb == 0) report_failure("no non-branch entry was resolved");
		report_test("branch resolve", errs);

		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/rob_pkg.sv
design/rob_ptr_ctrl.sv
design/rob_entry_store.sv
design/rob_branch_check.sv
design/rob_top.sv
bench/rob_tb.sv
